/* bench/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module coreTb;

    localparam logic [6:0] OP = 7'b0110011, OPW = 7'b0111011, OPIMM = 7'b0010011;
    localparam logic [6:0] LOAD = 7'b0000011, LUI = 7'b0110111, AUIPC = 7'b0010111;
    localparam logic [6:0] JALR = 7'b1100111;
    localparam logic [6:0] MULDIV = 7'b0000001;

    logic              clk, rstN;
    logic [`ILEN-1:0]  inst;
    logic [`XLEN-1:0]  dataRdata, pc, dataAddr, dataWdata, haltPc;
    logic [7:0]        dataWmask;
    logic              dataRen, halted;
    logic [`ILEN-1:0]  rom [$];
    logic [`XLEN-1:0]  mem [64];
    logic [`XLEN-1:0]  expAddr [$];
    logic [`XLEN-1:0]  expVal [$];
    logic [7:0]        expMask [$];
    int                errCount, storeIdx, cycles, cycleLimit, slot;

    coreTop dut (
        .clk(clk), .rstN(rstN), .inst(inst), .dataRdata(dataRdata), .pc(pc),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWmask(dataWmask),
        .dataRen(dataRen), .halted(halted)
    );

    assign dataRdata = mem[dataAddr[8:3]];  // doubleword aligned accesses only

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] encodeR(logic [6:0] op, logic [6:0] f7, logic [2:0] f3,
                                            logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeI(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(logic [2:0] f3, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};  // base is always x0
    endfunction

    function automatic logic [31:0] encodeB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                            logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encodeJ(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [63:0] maskBytes(logic [63:0] v, logic [7:0] m);
        logic [63:0] r;
        for (int b = 0; b < 8; b++) begin
            r[8*b +: 8] = m[b] ? v[8*b +: 8] : 8'h00;
        end
        return r;
    endfunction

    function automatic logic [31:0] fetch(logic [63:0] addr);
        int idx;
        idx = int'(addr >> 2);
        return (idx < rom.size()) ? rom[idx] : 32'h0000_0013;  // nop past the end
    endfunction

    task automatic emit(input logic [31:0] word);
        rom.push_back(word);
    endtask

    task automatic expectStore(input logic [63:0] addr, input logic [7:0] mask,
                               input logic [63:0] val);
        expAddr.push_back(addr);
        expMask.push_back(mask);
        expVal.push_back(val);
    endtask

    // sd rs into the next result slot
    task automatic storeResult(input logic [4:0] rs, input logic [63:0] val);
        emit(encodeS(3'b011, rs, 12'(slot * 8)));
        expectStore(64'(slot * 8), 8'hFF, val);
        slot++;
    endtask

    // marker 2 when taken, 1 when not
    task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input bit taken);
        emit(encodeB(f3, rs1, rs2, 13'd12));
        emit(encodeI(OPIMM, 3'b000, 5'd30, 5'd0, 12'd1));
        emit(encodeJ(5'd0, 21'd8));
        emit(encodeI(OPIMM, 3'b000, 5'd30, 5'd0, 12'd2));
        storeResult(5'd30, taken ? 64'd2 : 64'd1);
    endtask

    task automatic buildProgram();
        logic [63:0] p;
        emit(encodeI(OPIMM, 3'b000, 5'd1, 5'd0, 12'd100));
        emit(encodeI(OPIMM, 3'b000, 5'd2, 5'd0, 12'hFF9));  // -7
        emit(encodeR(OP, 7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        storeResult(5'd3, 64'd93);
        emit(encodeR(OP, 7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
        storeResult(5'd4, -64'd107);
        emit(encodeR(OP, 7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
        storeResult(5'd5, 64'hFFFF_FFFF_FFFF_FF9D);
        emit(encodeR(OP, 7'h00, 3'b110, 5'd5, 5'd1, 5'd2));
        storeResult(5'd5, 64'hFFFF_FFFF_FFFF_FFFD);
        emit(encodeR(OP, 7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        storeResult(5'd5, 64'h60);
        emit(encodeI(OPIMM, 3'b000, 5'd6, 5'd0, 12'd3));
        emit(encodeR(OP, 7'h00, 3'b001, 5'd7, 5'd1, 5'd6));
        storeResult(5'd7, 64'd800);
        emit(encodeR(OP, 7'h00, 3'b101, 5'd8, 5'd2, 5'd6));
        storeResult(5'd8, 64'h1FFF_FFFF_FFFF_FFFF);
        emit(encodeR(OP, 7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
        storeResult(5'd9, 64'd1);
        emit(encodeR(OP, 7'h00, 3'b011, 5'd10, 5'd2, 5'd1));
        storeResult(5'd10, 64'd0);
        emit({20'h12345, 5'd11, LUI});
        storeResult(5'd11, 64'h1234_5000);
        p = 64'(rom.size() * 4);
        emit({20'h00001, 5'd12, AUIPC});
        storeResult(5'd12, p + 64'h1000);
        emit(encodeR(OP, MULDIV, 3'b000, 5'd13, 5'd1, 5'd2));
        storeResult(5'd13, -64'd700);
        // word forms
        emit({20'h7FFFF, 5'd14, LUI});
        emit(encodeR(OPW, 7'h00, 3'b000, 5'd15, 5'd14, 5'd14));
        storeResult(5'd15, 64'hFFFF_FFFF_FFFF_E000);
        emit(encodeR(OPW, 7'h20, 3'b000, 5'd16, 5'd0, 5'd1));
        storeResult(5'd16, -64'd100);
        emit(encodeR(OPW, MULDIV, 3'b000, 5'd17, 5'd14, 5'd1));
        storeResult(5'd17, 64'hFFFF_FFFF_FFF9_C000);
        emit(encodeR(OPW, MULDIV, 3'b101, 5'd18, 5'd14, 5'd0));  // divide by zero
        storeResult(5'd18, '1);
        emit(encodeR(OPW, MULDIV, 3'b111, 5'd19, 5'd15, 5'd0));
        storeResult(5'd19, 64'hFFFF_FFFF_FFFF_E000);
        emit(encodeR(OPW, MULDIV, 3'b110, 5'd20, 5'd2, 5'd0));
        storeResult(5'd20, -64'd7);
        emit(encodeR(OPW, MULDIV, 3'b110, 5'd20, 5'd2, 5'd6));  // sign of the dividend
        storeResult(5'd20, -64'd1);
        // loads of a negative doubleword
        emit({20'h8001F, 5'd21, LUI});
        emit(encodeI(OPIMM, 3'b000, 5'd21, 5'd21, 12'h281));
        emit(encodeS(3'b011, 5'd21, 12'h1C0));
        expectStore(64'h1C0, 8'hFF, 64'hFFFF_FFFF_8001_F281);
        emit(encodeI(LOAD, 3'b000, 5'd22, 5'd0, 12'h1C0));
        storeResult(5'd22, 64'hFFFF_FFFF_FFFF_FF81);
        emit(encodeI(LOAD, 3'b001, 5'd22, 5'd0, 12'h1C0));
        storeResult(5'd22, 64'hFFFF_FFFF_FFFF_F281);
        emit(encodeI(LOAD, 3'b010, 5'd22, 5'd0, 12'h1C0));
        storeResult(5'd22, 64'hFFFF_FFFF_8001_F281);
        emit(encodeI(LOAD, 3'b100, 5'd22, 5'd0, 12'h1C0));
        storeResult(5'd22, 64'h81);
        emit(encodeI(LOAD, 3'b101, 5'd22, 5'd0, 12'h1C0));
        storeResult(5'd22, 64'hF281);
        emit(encodeS(3'b000, 5'd1, 12'h1C8));
        expectStore(64'h1C8, 8'h01, 64'h64);
        emit(encodeS(3'b001, 5'd2, 12'h1D0));
        expectStore(64'h1D0, 8'h03, 64'hFFF9);
        emit(encodeS(3'b010, 5'd2, 12'h1D8));
        expectStore(64'h1D8, 8'h0F, 64'hFFFF_FFF9);
        // x1 = 100, x2 = -7; bltu and bgeu flip the signed order
        branchCase(3'b000, 5'd1, 5'd1, 1'b1);
        branchCase(3'b000, 5'd1, 5'd2, 1'b0);
        branchCase(3'b001, 5'd1, 5'd2, 1'b1);
        branchCase(3'b001, 5'd1, 5'd1, 1'b0);
        branchCase(3'b100, 5'd2, 5'd1, 1'b1);
        branchCase(3'b100, 5'd1, 5'd2, 1'b0);
        branchCase(3'b101, 5'd1, 5'd2, 1'b1);
        branchCase(3'b101, 5'd2, 5'd1, 1'b0);
        branchCase(3'b110, 5'd1, 5'd2, 1'b1);
        branchCase(3'b110, 5'd2, 5'd1, 1'b0);
        branchCase(3'b111, 5'd2, 5'd1, 1'b1);
        branchCase(3'b111, 5'd1, 5'd2, 1'b0);
        p = 64'(rom.size() * 4);
        emit(encodeJ(5'd24, 21'd8));
        emit(encodeS(3'b011, 5'd0, 12'h1F8));  // skipped
        storeResult(5'd24, p + 64'd4);
        p = 64'(rom.size() * 4);
        emit({20'h00000, 5'd25, AUIPC});
        emit(encodeI(JALR, 3'b000, 5'd26, 5'd25, 12'd17));  // odd target, bit 0 dropped
        emit(encodeS(3'b011, 5'd0, 12'h1F8));
        emit(encodeS(3'b011, 5'd0, 12'h1F8));
        storeResult(5'd26, p + 64'd8);
        emit(32'h0010_0073);  // ebreak
        emit(encodeS(3'b011, 5'd1, 12'h1F0));  // must never run
    endtask

    task automatic reportAndFinish();
        $display("Errors: %0d, stores checked: %0d of %0d", errCount, storeIdx, expAddr.size());
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        inst = fetch(pc);
    end

    always @(posedge clk) begin
        if (rstN) begin
            cycles++;
            assert (dataRen == (inst[6:0] == LOAD)) else begin
                $display("Fail time=%0t dataRen expected=%b actual=%b",
                         $time, inst[6:0] == LOAD, dataRen);
                errCount++;
            end
            if (dataWmask != 8'h00) begin
                assert (storeIdx < expAddr.size()) else begin
                    $display("Unexpected store to %h at time %0t", dataAddr, $time);
                    errCount++;
                end
                if (storeIdx < expAddr.size()) begin
                    assert (dataAddr == expAddr[storeIdx]) else begin
                        $display("Fail time=%0t dataAddr expected=%h actual=%h",
                                 $time, expAddr[storeIdx], dataAddr);
                        errCount++;
                    end
                    assert (dataWmask == expMask[storeIdx]) else begin
                        $display("Fail time=%0t dataWmask expected=%h actual=%h",
                                 $time, expMask[storeIdx], dataWmask);
                        errCount++;
                    end
                    assert (maskBytes(dataWdata, dataWmask) == expVal[storeIdx]) else begin
                        $display("Fail time=%0t dataWdata expected=%h actual=%h",
                                 $time, expVal[storeIdx], maskBytes(dataWdata, dataWmask));
                        errCount++;
                    end
                    storeIdx++;
                end
                for (int b = 0; b < 8; b++) begin
                    if (dataWmask[b]) begin
                        mem[dataAddr[8:3]][8*b +: 8] <= dataWdata[8*b +: 8];
                    end
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        inst = 32'h0000_0013;
        errCount = 0;
        storeIdx = 0;
        cycles = 0;
        slot = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 64'hC0DE_0000_0000_0000 | 64'(i * 8);
        end
        buildProgram();
        cycleLimit = 4 * rom.size() + 20;
        repeat (8) begin
            @(negedge clk);
            assert (pc == `RESET_PC && !halted) else begin
                $display("Core left reset state while rstN was low at time %0t", $time);
                errCount++;
            end
        end
        rstN = 1'b1;
        #1;
        assert (pc == `RESET_PC && !halted) else begin
            $display("Core not in reset state at release, time %0t", $time);
            errCount++;
        end
        while (!halted && cycles < cycleLimit) begin
            @(negedge clk);
        end
        if (!halted) begin
            $display("Timeout: core did not halt within %0d cycles", cycleLimit);
            errCount++;
        end else begin
            haltPc = pc;
            repeat (6) begin
                @(negedge clk);
                assert (pc == haltPc && halted) else begin
                    $display("Fail time=%0t pc expected=%h actual=%h", $time, haltPc, pc);
                    errCount++;
                end
            end
            assert (storeIdx == expAddr.size()) else begin
                $display("Missing stores: only %0d of %0d seen", storeIdx, expAddr.size());
                errCount++;
            end
        end
        reportAndFinish();
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f rvCore.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/coreSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

/* rvCore.f */
+incdir+verilog
verilog/corePkg.sv
verilog/instDecoder.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/execAlu.sv
verilog/writeBack.sv
verilog/coreTop.sv
bench/coreTb.sv

/* verilog/corePkg.sv */
`default_nettype none

package corePkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluMul,
        aluDivu,
        aluRem,
        aluRemu,
        aluPassB,  // lui
        aluNone
    } aluOpT;

    typedef enum logic [1:0] {
        wbAluResult,
        wbMemData,
        wbPcPlus4,
        wbAluWord   // low word, sign extended
    } wbSelT;

    typedef enum logic {
        opndAPc,
        opndARs1
    } opndASelT;

    typedef enum logic {
        opndBImm,
        opndBRs2
    } opndBSelT;

endpackage

`default_nettype wire

/* verilog/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module coreTop import corePkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic [`ILEN-1:0] inst,
    input  logic [`XLEN-1:0] dataRdata,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWdata,
    output logic [7:0]       dataWmask,
    output logic             dataRen,
    output logic             halted
);

    aluOpT            aluOp;
    opndASelT         opndASel;
    opndBSelT         opndBSel;
    wbSelT            wbSel;
    logic             regWrite, memRead, loadSigned;
    logic             jump, jumpReg, haltReq;
    logic [7:0]       memWriteMask;
    logic [3:0]       loadBytes;
    logic [`XLEN-1:0] imm, rs1Val, rs2Val;
    logic [`XLEN-1:0] opndA, opndB, aluResult, rdData, nextPc;

    instDecoder uDecoder (
        .inst(inst), .rs1Val(rs1Val), .rs2Val(rs2Val),
        .aluOp(aluOp), .opndASel(opndASel), .opndBSel(opndBSel),
        .regWrite(regWrite), .wbSel(wbSel), .memWriteMask(memWriteMask),
        .memRead(memRead), .loadBytes(loadBytes), .loadSigned(loadSigned),
        .jump(jump), .jumpReg(jumpReg), .haltReq(haltReq)
    );

    immGen uImmGen (.inst(inst), .imm(imm));

    regFile uRegFile (
        .clk(clk), .rstN(rstN),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
        .rdWrite(regWrite && !halted), .rdData(rdData),
        .rs1Val(rs1Val), .rs2Val(rs2Val)
    );

    assign opndA = (opndASel == opndAPc) ? pc : rs1Val;
    assign opndB = (opndBSel == opndBImm) ? imm : rs2Val;

    // opcode bit 3 marks the word groups
    execAlu uAlu (.aluOp(aluOp), .opndA(opndA), .opndB(opndB), .wordOp(inst[3]),
                  .result(aluResult));

    writeBack uWriteBack (
        .wbSel(wbSel), .aluResult(aluResult), .memData(dataRdata), .pc(pc),
        .loadBytes(loadBytes), .loadSigned(loadSigned), .rdData(rdData)
    );

    assign nextPc = (jump && jumpReg) ? {aluResult[`XLEN-1:1], 1'b0} :
                    jump              ? pc + imm :
                                        pc + `XLEN'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else begin
            if (haltReq) begin
                halted <= 1'b1;
            end
            if (!halted) begin
                pc <= nextPc;
            end
        end
    end

    assign dataAddr  = aluResult;
    assign dataWdata = rs2Val;
    assign dataWmask = halted ? 8'h00 : memWriteMask;
    assign dataRen   = memRead && !halted;

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// register and data path width
`define XLEN 64

`define ILEN 32

// number of integer registers, x0 included
`define REG_COUNT 32

// address of the first fetched instruction
`define RESET_PC 64'h0000_0000_0000_0000

`endif

/* verilog/execAlu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module execAlu import corePkg::*; (
    input  aluOpT            aluOp,
    input  logic [`XLEN-1:0] opndA,
    input  logic [`XLEN-1:0] opndB,
    input  logic             wordOp,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] dividendU, divisorU;
    logic [`XLEN-1:0] dividendS, divisorS;
    logic             divZero;
    logic             divOverflow;
    logic [`XLEN-1:0] quotU, remU, remS;

    // word forms divide the low halves; signed values are sign extended first
    assign dividendU = wordOp ? {{(`XLEN-32){1'b0}}, opndA[31:0]} : opndA;
    assign divisorU  = wordOp ? {{(`XLEN-32){1'b0}}, opndB[31:0]} : opndB;
    assign dividendS = wordOp ? {{(`XLEN-32){opndA[31]}}, opndA[31:0]} : opndA;
    assign divisorS  = wordOp ? {{(`XLEN-32){opndB[31]}}, opndB[31:0]} : opndB;

    assign divZero     = (divisorU == '0);
    assign divOverflow = (dividendS == {1'b1, {(`XLEN-1){1'b0}}}) && (divisorS == '1);

    assign quotU = divZero ? '1 : dividendU / divisorU;
    assign remU  = divZero ? dividendU : dividendU % divisorU;
    assign remS  = divZero     ? dividendS :
                   divOverflow ? '0 :
                   $unsigned($signed(dividendS) % $signed(divisorS));

    always_comb begin
        case (aluOp)
            aluAdd:   result = opndA + opndB;
            aluSub:   result = opndA - opndB;
            aluXor:   result = opndA ^ opndB;
            aluOr:    result = opndA | opndB;
            aluAnd:   result = opndA & opndB;
            aluSll:   result = opndA << opndB[5:0];
            aluSrl:   result = opndA >> opndB[5:0];
            aluSlt:   result = `XLEN'($signed(opndA) < $signed(opndB));
            aluSltu:  result = `XLEN'(opndA < opndB);
            aluMul:   result = opndA * opndB;  // low half only
            aluDivu:  result = quotU;
            aluRem:   result = remS;
            aluRemu:  result = remU;
            aluPassB: result = opndB;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/immGen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module immGen (
    input  logic [`ILEN-1:0] inst,
    output logic [`XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (inst[6:0])
            7'b0010011, 7'b0011011, 7'b0000011, 7'b1100111, 7'b1110011:
                imm = {{(`XLEN-12){sign}}, inst[31:20]};               // I
            7'b0100011:
                imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};   // S
            7'b1100011:
                imm = {{(`XLEN-13){sign}}, sign, inst[7], inst[30:25],
                       inst[11:8], 1'b0};                              // B
            7'b0110111, 7'b0010111:
                imm = {{(`XLEN-32){sign}}, inst[31:12], 12'b0};        // U
            7'b1101111:
                imm = {{(`XLEN-21){sign}}, sign, inst[19:12], inst[20],
                       inst[30:21], 1'b0};                             // J
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module instDecoder import corePkg::*; (
    input  logic [`ILEN-1:0] inst,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    output aluOpT            aluOp,
    output opndASelT         opndASel,
    output opndBSelT         opndBSel,
    output logic             regWrite,
    output wbSelT            wbSel,
    output logic [7:0]       memWriteMask,
    output logic             memRead,
    output logic [3:0]       loadBytes,
    output logic             loadSigned,
    output logic             jump,
    output logic             jumpReg,
    output logic             haltReq
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       branchTaken;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // shared by the 64-bit and the word register-register groups
    function automatic aluOpT regRegOp(input logic [2:0] f3, input logic [6:0] f7,
                                       input logic isWord);
        aluOpT op;
        op = aluNone;
        if (f7 == 7'b0000001) begin
            case (f3)
                3'b000:  op = aluMul;
                3'b101:  op = aluDivu;
                3'b110:  op = aluRem;
                3'b111:  op = aluRemu;
                default: op = aluNone;
            endcase
        end else if (f7 == 7'b0100000) begin
            op = (f3 == 3'b000) ? aluSub : aluNone;
        end else if (f7 == 7'b0000000) begin
            case (f3)
                3'b000:  op = aluAdd;
                3'b001:  op = aluSll;
                3'b101:  op = aluSrl;
                3'b100:  op = aluXor;
                3'b110:  op = aluOr;
                3'b111:  op = aluAnd;
                3'b010:  op = aluSlt;
                3'b011:  op = aluSltu;
                default: op = aluNone;
            endcase
            if (isWord && f3 != 3'b000) begin
                op = aluNone;  // only addw in the word group
            end
        end
        return op;
    endfunction

    always_comb begin
        case (funct3)
            3'b000:  branchTaken = (rs1Val == rs2Val);
            3'b001:  branchTaken = (rs1Val != rs2Val);
            3'b100:  branchTaken = ($signed(rs1Val) < $signed(rs2Val));
            3'b101:  branchTaken = ($signed(rs1Val) >= $signed(rs2Val));
            3'b110:  branchTaken = (rs1Val < rs2Val);
            3'b111:  branchTaken = (rs1Val >= rs2Val);
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        aluOp        = aluNone;
        opndASel     = opndARs1;
        opndBSel     = opndBRs2;
        regWrite     = 1'b0;
        wbSel        = wbAluResult;
        memWriteMask = 8'h00;
        memRead      = 1'b0;
        loadBytes    = 4'd8;
        loadSigned   = 1'b1;
        jump         = 1'b0;
        jumpReg      = 1'b0;
        haltReq      = 1'b0;
        case (opcode)
            7'b0110011: begin  // register-register
                regWrite = 1'b1;
                aluOp    = regRegOp(funct3, funct7, 1'b0);
            end
            7'b0111011: begin  // word register-register
                regWrite = 1'b1;
                wbSel    = wbAluWord;
                aluOp    = regRegOp(funct3, funct7, 1'b1);
            end
            7'b0010011: begin  // register-immediate
                regWrite = 1'b1;
                opndBSel = opndBImm;
                case (funct3)
                    3'b000:  aluOp = aluAdd;
                    3'b100:  aluOp = aluXor;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    3'b010:  aluOp = aluSlt;
                    3'b011:  aluOp = aluSltu;
                    3'b001:  aluOp = (inst[31:26] == 6'b0) ? aluSll : aluNone;
                    3'b101:  aluOp = (inst[31:26] == 6'b0) ? aluSrl : aluNone;
                    default: aluOp = aluNone;
                endcase
            end
            7'b0011011: begin  // addiw
                regWrite = 1'b1;
                opndBSel = opndBImm;
                wbSel    = wbAluWord;
                aluOp    = (funct3 == 3'b000) ? aluAdd : aluNone;
            end
            7'b0010111: begin  // auipc
                regWrite = 1'b1;
                opndASel = opndAPc;
                opndBSel = opndBImm;
                aluOp    = aluAdd;
            end
            7'b0110111: begin  // lui
                regWrite = 1'b1;
                opndBSel = opndBImm;
                aluOp    = aluPassB;
            end
            7'b0000011: begin
                regWrite = 1'b1;
                opndBSel = opndBImm;
                aluOp    = aluAdd;
                wbSel    = wbMemData;
                memRead  = 1'b1;
                loadBytes  = 4'd1 << funct3[1:0];
                loadSigned = ~funct3[2];  // lbu lhu lwu
            end
            7'b0100011: begin
                opndBSel     = opndBImm;
                aluOp        = aluAdd;
                memWriteMask = (funct3[2] == 1'b0) ? 8'((16'h1 << (4'd1 << funct3[1:0])) - 1)
                                                   : 8'h00;
            end
            7'b1100011: jump = branchTaken;
            7'b1101111: begin  // jal
                regWrite = 1'b1;
                wbSel    = wbPcPlus4;
                jump     = 1'b1;
            end
            7'b1100111: begin  // jalr, target from the alu
                regWrite = 1'b1;
                wbSel    = wbPcPlus4;
                opndBSel = opndBImm;
                aluOp    = aluAdd;
                jump     = 1'b1;
                jumpReg  = 1'b1;
            end
            7'b1110011: haltReq = (inst == 32'h0010_0073);  // ebreak only
            default: ;
        endcase
    end

    always_comb begin
        assert (!(memRead && memWriteMask != 8'h00))
            else $error("load and store decoded together");
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module regFile (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [$clog2(`REG_COUNT)-1:0]    rs1Addr,
    input  logic [$clog2(`REG_COUNT)-1:0]    rs2Addr,
    input  logic [$clog2(`REG_COUNT)-1:0]    rdAddr,
    input  logic                             rdWrite,
    input  logic [`XLEN-1:0]                 rdData,
    output logic [`XLEN-1:0]                 rs1Val,
    output logic [`XLEN-1:0]                 rs2Val
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];  // no storage for x0

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrite && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Val = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    // a write aimed at x0 must leave it reading zero
    assert property (@(posedge clk) disable iff (!rstN)
        rdWrite && rdAddr == '0 |=> rs1Addr != '0 || rs1Val == '0);

endmodule

`default_nettype wire

/* verilog/writeBack.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module writeBack import corePkg::*; (
    input  wbSelT            wbSel,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] memData,
    input  logic [`XLEN-1:0] pc,
    input  logic [3:0]       loadBytes,
    input  logic             loadSigned,
    output logic [`XLEN-1:0] rdData
);

    logic [`XLEN-1:0] loadVal;

    // data sits in the low bytes of the returned doubleword
    always_comb begin
        case (loadBytes)
            4'd1: loadVal = {{(`XLEN-8){loadSigned & memData[7]}}, memData[7:0]};
            4'd2: loadVal = {{(`XLEN-16){loadSigned & memData[15]}}, memData[15:0]};
            4'd4: loadVal = {{(`XLEN-32){loadSigned & memData[31]}}, memData[31:0]};
            default: loadVal = memData;
        endcase
    end

    always_comb begin
        case (wbSel)
            wbMemData: rdData = loadVal;
            wbPcPlus4: rdData = pc + `XLEN'd4;  // link address
            wbAluWord: rdData = {{(`XLEN-32){aluResult[31]}}, aluResult[31:0]};
            default:   rdData = aluResult;
        endcase
    end

endmodule

`default_nettype wire
